/* include/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

`define ALU_W  64
`define FLAG_W 6

// opcodes, add through xnor are the flag-setting group
`define OP_ADD  4'd0
`define OP_SUB  4'd1
`define OP_AND  4'd2
`define OP_OR   4'd3
`define OP_XOR  4'd4
`define OP_XNOR 4'd5
`define OP_MOV  4'd6
`define OP_ZXT  4'd7
`define OP_SXT  4'd8
`define OP_CMOV 4'd9
`define OP_CSET 4'd10

`define SZ_8  2'd0
`define SZ_16 2'd1
`define SZ_32 2'd2
`define SZ_64 2'd3

`define CC_Z      4'd0
`define CC_NZ     4'd1
`define CC_S      4'd2
`define CC_NS     4'd3
`define CC_UGT    4'd4
`define CC_ULE    4'd5
`define CC_UGE    4'd6
`define CC_ULT    4'd7
`define CC_SGT    4'd8
`define CC_SLE    4'd9
`define CC_SGE    4'd10
`define CC_SLT    4'd11
`define CC_O      4'd12
`define CC_NO     4'd13
`define CC_P      4'd14
`define CC_ALWAYS 4'd15

`endif

/* src/alu_pkg.sv */
`include "alu_cfg.svh"

package alu_pkg;

  // COASZP order, c is the msb
  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } alu_flags_t;

  typedef struct packed {
    logic       no_flags;
    logic [1:0] src_size; // source width for zxt/sxt
    logic [1:0] size;
    logic [3:0] op;
  } alu_arith_t;

  typedef struct packed {
    logic       no_flags;
    logic [3:0] cond;
    logic [3:0] op;
  } alu_cond_t;

  // cmov and cset read the cond view
  typedef union packed {
    alu_arith_t arith;
    alu_cond_t  cond;
  } alu_op_u;

  typedef struct packed {
    logic              valid;
    alu_op_u           op;
    logic [`ALU_W-1:0] a;
    logic [`ALU_W-1:0] b;
    alu_flags_t        flags; // incoming flags for conditional ops
  } alu_req_t;

  typedef struct packed {
    logic              valid;
    logic [`ALU_W-1:0] result;
    alu_flags_t        flags;
    logic              sets_flags;
  } alu_rsp_t;

endpackage

/* src/cond_eval.sv */
`include "alu_cfg.svh"

module cond_eval (
  input  alu_pkg::alu_flags_t flags,
  input  logic [3:0]          cond,
  output logic                take
);

  logic slt; // signed less than

  assign slt = flags.s ^ flags.o;

  always_comb
  begin
    case (cond)
      `CC_Z:      take = flags.z;
      `CC_NZ:     take = ~flags.z;
      `CC_S:      take = flags.s;
      `CC_NS:     take = ~flags.s;
      `CC_UGT:    take = ~flags.c & ~flags.z;
      `CC_ULE:    take = flags.c | flags.z;
      `CC_UGE:    take = ~flags.c;
      `CC_ULT:    take = flags.c;
      `CC_SGT:    take = ~slt & ~flags.z;
      `CC_SLE:    take = slt | flags.z;
      `CC_SGE:    take = ~slt;
      `CC_SLT:    take = slt;
      `CC_O:      take = flags.o;
      `CC_NO:     take = ~flags.o;
      `CC_P:      take = flags.p;
      default:    take = 1'b1; // always
    endcase
  end

endmodule

/* src/alu_adder.sv */
`include "alu_cfg.svh"

module alu_adder (
  input  logic [`ALU_W-1:0]   a,
  input  logic [`ALU_W-1:0]   b,
  input  logic [1:0]          size,
  input  logic                sub,
  output logic [`ALU_W-1:0]   sum,
  output alu_pkg::alu_flags_t cflags
);

  logic [`ALU_W-1:0] bx;
  logic c4;
  logic c8;
  logic c16;
  logic c32;
  logic c64;
  logic o8;
  logic o16;
  logic o32;
  logic o64;
  logic carry;
  logic ovf;

  assign bx = sub ? ~b : b; // subtract as a + ~b + 1

  // carry chain split at the flag tap points
  always_comb
  begin
    {c4, sum[3:0]} = {1'b0, a[3:0]} + {1'b0, bx[3:0]} + {4'b0, sub};
    {c8, sum[7:4]} = {1'b0, a[7:4]} + {1'b0, bx[7:4]} + {4'b0, c4};
    {c16, sum[15:8]} = {1'b0, a[15:8]} + {1'b0, bx[15:8]} + {8'b0, c8};
    {c32, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'b0, c16};
    {c64, sum[`ALU_W-1:32]} = {1'b0, a[`ALU_W-1:32]} + {1'b0, bx[`ALU_W-1:32]}
                            + {{(`ALU_W-32){1'b0}}, c32};
  end

  // operands of equal sign giving a result of the other sign
  assign o8  = (a[7] ~^ bx[7]) & (a[7] ^ sum[7]);
  assign o16 = (a[15] ~^ bx[15]) & (a[15] ^ sum[15]);
  assign o32 = (a[31] ~^ bx[31]) & (a[31] ^ sum[31]);
  assign o64 = (a[`ALU_W-1] ~^ bx[`ALU_W-1]) & (a[`ALU_W-1] ^ sum[`ALU_W-1]);

  always_comb
  begin
    case (size)
      `SZ_8:
      begin
        carry = c8;
        ovf = o8;
      end
      `SZ_16:
      begin
        carry = c16;
        ovf = o16;
      end
      `SZ_32:
      begin
        carry = c32;
        ovf = o32;
      end
      default:
      begin
        carry = c64;
        ovf = o64;
      end
    endcase
  end

  always_comb
  begin
    cflags = '0;
    cflags.c = carry ^ sub; // borrow is the inverted carry
    cflags.o = ovf;
    cflags.a = c4 ^ sub;
  end

endmodule

/* src/alu_logic.sv */
`include "alu_cfg.svh"

module alu_logic (
  input  alu_pkg::alu_op_u  op,
  input  logic [`ALU_W-1:0] a,
  input  logic [`ALU_W-1:0] b,
  input  logic              take,
  output logic [`ALU_W-1:0] value
);

  logic [`ALU_W-1:0] zext;
  logic [`ALU_W-1:0] sext;

  // extensions take their width from src_size, not size
  always_comb
  begin
    case (op.arith.src_size)
      `SZ_8:
      begin
        zext = {{(`ALU_W-8){1'b0}}, b[7:0]};
        sext = {{(`ALU_W-8){b[7]}}, b[7:0]};
      end
      `SZ_16:
      begin
        zext = {{(`ALU_W-16){1'b0}}, b[15:0]};
        sext = {{(`ALU_W-16){b[15]}}, b[15:0]};
      end
      `SZ_32:
      begin
        zext = {{(`ALU_W-32){1'b0}}, b[31:0]};
        sext = {{(`ALU_W-32){b[31]}}, b[31:0]};
      end
      default:
      begin
        zext = b;
        sext = b;
      end
    endcase
  end

  // logic ops and mov come out unmerged, the result stage applies size
  always_comb
  begin
    case (op.arith.op)
      `OP_AND:
        value = a & b;
      `OP_OR:
        value = a | b;
      `OP_XOR:
        value = a ^ b;
      `OP_XNOR:
        value = ~(a ^ b);
      `OP_MOV:
        value = b;
      `OP_ZXT:
        value = zext;
      `OP_SXT:
        value = sext;
      `OP_CMOV:
        value = take ? b : a;
      `OP_CSET:
        value = {{(`ALU_W-1){1'b0}}, take};
      default:
        value = '0; // add/sub use the adder path
    endcase
  end

endmodule

/* src/alu_result_stage.sv */
`include "alu_cfg.svh"

module alu_result_stage (
  input  logic                clk,
  input  logic                rst,
  input  alu_pkg::alu_req_t   req,
  input  logic [`ALU_W-1:0]   sum,
  input  alu_pkg::alu_flags_t cflags,
  input  logic [`ALU_W-1:0]   value,
  output alu_pkg::alu_rsp_t   rsp
);

  logic [3:0]          op;
  logic                is_arith;
  logic                is_merge;
  logic                sets_flags;
  logic [`ALU_W-1:0]   raw;
  logic [`ALU_W-1:0]   merged;
  logic                sign;
  logic                zero;
  logic [`FLAG_W-1:0]  flag_mask;
  alu_pkg::alu_flags_t flags;
  alu_pkg::alu_rsp_t   rsp_d;

  assign op = req.op.arith.op;
  assign is_arith = (op == `OP_ADD) || (op == `OP_SUB);
  assign is_merge = op <= `OP_MOV; // add through mov obey the size merge
  assign sets_flags = req.valid && (op <= `OP_XNOR) && !req.op.arith.no_flags;
  assign raw = is_arith ? sum : value;

  // 8 and 16 bit ops keep the upper part of a, 32 bit zero extends
  always_comb
  begin
    case (req.op.arith.size)
      `SZ_8:
      begin
        merged = {req.a[`ALU_W-1:8], raw[7:0]};
        sign = raw[7];
        zero = raw[7:0] == 8'b0;
      end
      `SZ_16:
      begin
        merged = {req.a[`ALU_W-1:16], raw[15:0]};
        sign = raw[15];
        zero = raw[15:0] == 16'b0;
      end
      `SZ_32:
      begin
        merged = {{(`ALU_W-32){1'b0}}, raw[31:0]};
        sign = raw[31];
        zero = raw[31:0] == 32'b0;
      end
      default:
      begin
        merged = raw;
        sign = raw[`ALU_W-1];
        zero = raw == '0;
      end
    endcase
  end

  always_comb
  begin
    flags = '0;
    if (is_arith)
    begin
      flags.c = cflags.c;
      flags.o = cflags.o;
      flags.a = cflags.a;
    end
    flags.s = sign;
    flags.z = zero;
    flags.p = ~^raw[7:0]; // set on an even count of ones
  end

  assign flag_mask = {`FLAG_W{sets_flags}};

  always_comb
  begin
    rsp_d.valid = req.valid;
    rsp_d.result = is_merge ? merged : value;
    rsp_d.flags = flags & flag_mask;
    rsp_d.sets_flags = sets_flags;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rsp <= '0;
    else
      rsp <= rsp_d;
  end

endmodule

/* src/int_alu.sv */
`include "alu_cfg.svh"

module int_alu (
  input  logic              clk,
  input  logic              rst,
  input  alu_pkg::alu_req_t req,
  output alu_pkg::alu_rsp_t rsp
);

  logic                take;
  logic [`ALU_W-1:0]   sum;
  logic [`ALU_W-1:0]   value;
  alu_pkg::alu_flags_t cflags;

  cond_eval cond_eval_inst (
    .flags (req.flags),
    .cond  (req.op.cond.cond),
    .take  (take)
  );

  alu_adder alu_adder_inst (
    .a      (req.a),
    .b      (req.b),
    .size   (req.op.arith.size),
    .sub    (req.op.arith.op == `OP_SUB),
    .sum    (sum),
    .cflags (cflags)
  );

  alu_logic alu_logic_inst (
    .op    (req.op),
    .a     (req.a),
    .b     (req.b),
    .take  (take),
    .value (value)
  );

  // single register stage, one cycle from req to rsp
  alu_result_stage alu_result_stage_inst (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .sum    (sum),
    .cflags (cflags),
    .value  (value),
    .rsp    (rsp)
  );

endmodule

/* test/alu_chk.sv */
module alu_chk (
  input logic              clk,
  input logic              rst,
  input alu_pkg::alu_req_t req,
  input alu_pkg::alu_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // reset clears the response strobe
  assert property (@(posedge clk) rst |=> !rsp.valid)
    else $error("rsp.valid set in the cycle after reset");

  // single stage, strobe delayed by one clock
  assert property (@(posedge clk) !rst |=> (rsp.valid == $past(req.valid)))
    else $error("rsp.valid does not follow req.valid by one cycle");

  assert property (@(posedge clk) rsp.sets_flags |-> rsp.valid)
    else $error("rsp.sets_flags set without rsp.valid");

endmodule

bind int_alu alu_chk alu_chk_inst (
  .clk (clk),
  .rst (rst),
  .req (req),
  .rsp (rsp)
);

/* test/alu_tb.sv */
`include "alu_cfg.svh"

module alu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic              clk;
  logic              rst;
  alu_pkg::alu_req_t req;
  alu_pkg::alu_rsp_t rsp;
  logic [31:0]       lfsr_state = 32'h3f0e160a;
  alu_pkg::alu_rsp_t expect_q[$];

  int_alu int_alu_inst (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] corner_value(input logic [2:0] k);
    case (k)
      3'd0: return 64'h0000_0000_0000_0000;
      3'd1: return 64'hffff_ffff_ffff_ffff;
      3'd2: return 64'h0000_0000_0000_0001;
      3'd3: return 64'h8000_0000_0000_0000; // sign bit only
      3'd4: return 64'h7fff_ffff_ffff_ffff;
      3'd5: return 64'h0000_0000_8000_0000;
      3'd6: return 64'h0000_0000_0000_8000;
      default: return 64'h0000_0000_0000_0080;
    endcase
  endfunction

  function automatic logic cond_holds(input alu_pkg::alu_flags_t f, input logic [3:0] cc);
    logic sge;
    sge = (f.s == f.o);
    case (cc)
      `CC_Z:   return f.z;
      `CC_NZ:  return !f.z;
      `CC_S:   return f.s;
      `CC_NS:  return !f.s;
      `CC_UGT: return !f.c && !f.z;
      `CC_ULE: return f.c || f.z;
      `CC_UGE: return !f.c;
      `CC_ULT: return f.c;
      `CC_SGT: return sge && !f.z;
      `CC_SLE: return !sge || f.z;
      `CC_SGE: return sge;
      `CC_SLT: return !sge;
      `CC_O:   return f.o;
      `CC_NO:  return !f.o;
      `CC_P:   return f.p;
      default: return 1'b1;
    endcase
  endfunction

  // expected response one cycle after r
  function automatic alu_pkg::alu_rsp_t model(input alu_pkg::alu_req_t r);
    alu_pkg::alu_rsp_t e;
    logic [3:0]        opc;
    int                w;
    int                sw;
    logic [63:0]       mask;
    logic [63:0]       smask;
    logic [64:0]       full;
    logic [63:0]       raw;
    logic [4:0]        nib;
    logic              sa;
    logic              sb;
    logic              sr;
    opc = r.op.arith.op;
    w = 8 << r.op.arith.size;
    sw = 8 << r.op.arith.src_size;
    mask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
    smask = (sw == 64) ? {64{1'b1}} : ((64'd1 << sw) - 64'd1);
    e = '0;
    raw = '0;
    e.valid = r.valid;
    e.sets_flags = r.valid && !r.op.arith.no_flags
                   && (opc inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_XNOR});
    case (opc)
      `OP_ADD, `OP_SUB:
      begin
        sa = r.a[w-1];
        sb = r.b[w-1];
        if (opc == `OP_ADD)
        begin
          full = {1'b0, r.a & mask} + {1'b0, r.b & mask};
          raw = full[63:0];
          sr = raw[w-1];
          nib = {1'b0, r.a[3:0]} + {1'b0, r.b[3:0]};
          e.flags.c = full[w];
          e.flags.o = (sa == sb) && (sr != sa);
          e.flags.a = nib[4];
        end
        else
        begin
          full = {1'b0, r.a & mask} - {1'b0, r.b & mask};
          raw = full[63:0];
          sr = raw[w-1];
          e.flags.c = (r.a & mask) < (r.b & mask); // borrow
          e.flags.o = (sa != sb) && (sr != sa);
          e.flags.a = r.a[3:0] < r.b[3:0];
        end
      end
      `OP_AND:  raw = r.a & r.b;
      `OP_OR:   raw = r.a | r.b;
      `OP_XOR:  raw = r.a ^ r.b;
      `OP_XNOR: raw = ~(r.a ^ r.b);
      `OP_MOV:  raw = r.b;
      `OP_ZXT:  e.result = r.b & smask;
      `OP_SXT:  e.result = r.b[sw-1] ? (r.b | ~smask) : (r.b & smask);
      `OP_CMOV: e.result = cond_holds(r.flags, r.op.cond.cond) ? r.b : r.a;
      default:  e.result = 64'(cond_holds(r.flags, r.op.cond.cond));
    endcase
    if (opc <= `OP_MOV)
    begin
      if (w == 64)
        e.result = raw;
      else if (w == 32)
        e.result = raw & mask;
      else
        e.result = (r.a & ~mask) | (raw & mask);
      e.flags.s = raw[w-1];
      e.flags.z = (raw & mask) == 64'd0;
      e.flags.p = ~^raw[7:0];
    end
    if (!e.sets_flags)
      e.flags = '0;
    return e;
  endfunction

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic make_request(input logic force_valid, output alu_pkg::alu_req_t r);
    logic [63:0] bits;
    logic [3:0]  opc;
    r = '0;
    bits = rand_bits(2);
    r.valid = force_valid || (bits[1:0] != 2'b00);
    bits = rand_bits(4);
    opc = bits[3:0];
    if (opc > `OP_CSET)
      opc = opc - 4'd5;
    if (opc == `OP_CMOV || opc == `OP_CSET)
    begin
      bits = rand_bits(4);
      r.op.cond.cond = bits[3:0];
      r.op.cond.op = opc;
    end
    else
    begin
      bits = rand_bits(2);
      r.op.arith.size = bits[1:0];
      bits = rand_bits(2);
      r.op.arith.src_size = bits[1:0];
      r.op.arith.op = opc;
    end
    bits = rand_bits(2);
    r.op.arith.no_flags = (bits[1:0] == 2'b00); // same bit in both views
    bits = rand_bits(3);
    if (bits[2:0] == 3'd0)
    begin
      bits = rand_bits(3);
      r.a = corner_value(bits[2:0]);
      bits = rand_bits(3);
      r.b = corner_value(bits[2:0]);
    end
    else
    begin
      r.a = rand_bits(64);
      r.b = rand_bits(64);
    end
    bits = rand_bits(6);
    r.flags = bits[5:0];
  endtask

  task automatic compare_response();
    alu_pkg::alu_rsp_t e;
    if (expect_q.size() == 0)
    begin
      $display("a response was due but the model queue is empty");
      end_with_failure();
    end
    e = expect_q.pop_front();
    check_equal("rsp.valid", {63'b0, rsp.valid}, {63'b0, e.valid});
    check_equal("rsp.sets_flags", {63'b0, rsp.sets_flags}, {63'b0, e.sets_flags});
    check_equal("rsp.flags", {58'b0, rsp.flags}, {58'b0, e.flags});
    if (e.valid)
      check_equal("rsp.result", rsp.result, e.result);
  endtask

  // called on a falling edge and returns on the next one
  task automatic drive_and_check(input logic force_valid);
    alu_pkg::alu_req_t nreq;
    make_request(force_valid, nreq);
    req = nreq;
    expect_q.push_back(model(nreq));
    @(negedge clk);
    compare_response();
  endtask

  // idles the bus while waiting for rsp.valid
  task automatic wait_for_response(input int limit, output int cycles);
    alu_pkg::alu_req_t idle;
    idle = '0;
    cycles = 0;
    do
    begin
      @(negedge clk);
      req = idle;
      cycles++;
    end
    while (!rsp.valid && cycles < limit);
    if (!rsp.valid)
    begin
      $display("timeout: no rsp.valid within %0d cycles of a request", limit);
      end_with_failure();
    end
  endtask

  initial
  begin
    alu_pkg::alu_req_t nreq;
    int cycles;
    rst = 1'b1;
    req = '0;
    // reset has to clear the register under live traffic
    repeat (7)
    begin
      @(negedge clk);
      make_request(1'b1, nreq);
      req = nreq;
    end
    @(negedge clk);
    check_equal("rsp.valid", {63'b0, rsp.valid}, 64'd0);
    check_equal("rsp.result", rsp.result, 64'd0);
    check_equal("rsp.flags", {58'b0, rsp.flags}, 64'd0);
    check_equal("rsp.sets_flags", {63'b0, rsp.sets_flags}, 64'd0);
    rst = 1'b0;

    // latency of an isolated request must be one cycle
    for (int n = 0; n < 8; n++)
    begin
      make_request(1'b1, nreq);
      req = nreq;
      expect_q.push_back(model(nreq));
      wait_for_response(4, cycles);
      check_equal("latency", 64'(cycles), 64'd1);
      compare_response();
    end

    for (int n = 0; n < 64; n++)
      drive_and_check(1'b1); // back to back
    for (int n = 0; n < 4000; n++)
      drive_and_check(1'b0);

    req = '0;
    @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
src/alu_pkg.sv
src/cond_eval.sv
src/alu_adder.sv
src/alu_logic.sv
src/alu_result_stage.sv
src/int_alu.sv
test/alu_chk.sv
test/alu_tb.sv

/* run.sh */
#!/bin/sh
# build the ALU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module alu_tb -Mdir obj_dir -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Valu_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
